/* dv/synth_engine_asserts.sv */
module synth_engine_asserts (
    input logic                audio_clk,
    input logic                arst_n,
    input logic                cmd_valid,
    input logic                cmd_ready,
    input synth_pkg::reg_cmd_t cmd,
    input logic                sample_valid,
    input logic                sample_ready,
    input synth_pkg::stereo_t  sample
);

    cmd_hold: assert property (@(posedge audio_clk) disable iff (!arst_n)
        cmd_valid && !cmd_ready |=> $stable(cmd))
        else $error("cmd changed while waiting for cmd_ready");

    sample_hold: assert property (@(posedge audio_clk) disable iff (!arst_n)
        sample_valid && !sample_ready |=> sample_valid && $stable(sample))
        else $error("sample dropped or changed before it was accepted");

    reset_idle: assert property (@(posedge audio_clk)
        $rose(arst_n) |-> !sample_valid)
        else $error("sample_valid high coming out of reset");

endmodule

bind synth_engine synth_engine_asserts u_asserts (.*);

/* dv/synth_engine_tb.sv */
module synth_engine_tb;

    localparam int TMO = 4000;                  // cycles per wait
    localparam logic [1:0] RDY_LOW  = 2'd0;
    localparam logic [1:0] RDY_HIGH = 2'd1;
    localparam logic [1:0] RDY_RAND = 2'd2;

    typedef struct packed {
        logic [7:0] first;                      // index into wr_tab
        logic [7:0] count;
        logic [7:0] frames;
        logic [1:0] mode;
        logic       live;                       // writes issued while frames run
        logic [1:0] voice;                      // voice for check_param
    } step_t;

    // address byte then data byte
    localparam logic [15:0] WR_TAB [38] = '{
        16'h4001, 16'h0755, 16'hF2FF, 16'h0A11,
        16'h33C0, 16'h3440, 16'h3520, 16'h3601,
        16'h0000, 16'h0108, 16'h03FF, 16'h0430, 16'h0600, 16'h0201,
        16'h0540, 16'h0200,
        16'h0034, 16'h0112, 16'h04FF, 16'h0201,
        16'h1000, 16'h1109, 16'h13F0, 16'h1480, 16'h1601, 16'h1201,
        16'h2040, 16'h210C, 16'h23FF, 16'h24FF, 16'h2602, 16'h2201,
        16'h3105, 16'h3603, 16'h3201,
        16'h1200, 16'h1510, 16'h2340};

    localparam step_t STEPS [7] = '{
        '{8'd0,  8'd4,  8'd4,  RDY_HIGH, 1'b0, 2'd0},
        '{8'd4,  8'd4,  8'd6,  RDY_RAND, 1'b1, 2'd3},
        '{8'd8,  8'd6,  8'd10, RDY_HIGH, 1'b0, 2'd0},
        '{8'd14, 8'd2,  8'd8,  RDY_HIGH, 1'b0, 2'd0},
        '{8'd16, 8'd19, 8'd12, RDY_HIGH, 1'b0, 2'd2},
        '{8'd35, 8'd0,  8'd16, RDY_RAND, 1'b0, 2'd1},
        '{8'd35, 8'd3,  8'd8,  RDY_RAND, 1'b0, 2'd2}};

    string names [7] = '{"idle_zero", "live_writes", "center_attack", "release",
                         "mixed_pan", "random_ready", "late_write"};

    logic                audio_clk;
    logic                arst_n;
    logic                cmd_valid;
    logic                cmd_ready;
    synth_pkg::reg_cmd_t cmd;
    logic                sample_valid;
    logic                sample_ready;
    synth_pkg::stereo_t  sample;

    logic [1:0]              ready_mode;
    logic [15:0]             lfsr;
    synth_pkg::stereo_t      got_q [$];
    synth_pkg::stereo_t      exp_q [$];
    int                      n_cmp;
    synth_pkg::voice_param_t m_par [synth_pkg::VOICES];   // reference model state
    int                      m_phase [synth_pkg::VOICES];
    int                      m_level [synth_pkg::VOICES];

    synth_engine dut (.*);

    always #4 audio_clk = ~audio_clk;

    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    always @(posedge audio_clk) begin
        #1;
        if (ready_mode == RDY_RAND) begin
            lfsr = lfsr_step(lfsr);
            sample_ready = lfsr[0];
        end else begin
            sample_ready = (ready_mode == RDY_HIGH);
        end
    end

    always @(negedge audio_clk) begin
        if (arst_n && sample_valid && sample_ready) begin
            got_q.push_back(sample);            // accepted at the next rising edge
        end
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_stereo(string name, synth_pkg::stereo_t exp, synth_pkg::stereo_t act);
        if (act !== exp) begin
            abort_run($sformatf("** Error %s: expected L=%0d R=%0d, actual L=%0d R=%0d",
                name, exp.left, exp.right, act.left, act.right));
        end
    endtask

    task automatic check_param(string name, synth_pkg::voice_param_t exp,
                               synth_pkg::voice_param_t act);
        if (act !== exp) begin
            abort_run($sformatf("** Error %s: expected params %h, actual %h", name, exp, act));
        end
    endtask

    function automatic logic signed [15:0] clip16(int x);
        if (x > 32767) begin
            return 16'sh7fff;
        end else if (x < -32768) begin
            return 16'sh8000;
        end
        return x[15:0];
    endfunction

    function automatic void model_write(synth_pkg::reg_cmd_t c);
        int v;
        v = int'(c.addr[7:4]);
        if (v >= synth_pkg::VOICES) begin
            return;                             // voice out of range
        end
        case (c.addr[3:0])
            synth_pkg::REG_INC_LO:  m_par[v].inc[7:0] = c.data;
            synth_pkg::REG_INC_HI:  m_par[v].inc[15:8] = c.data;
            synth_pkg::REG_GATE:    m_par[v].gate = c.data[0];
            synth_pkg::REG_VEL:     m_par[v].vel = c.data;
            synth_pkg::REG_ATTACK:  m_par[v].atk = c.data;
            synth_pkg::REG_RELEASE: m_par[v].rel = c.data;
            synth_pkg::REG_PAN:     m_par[v].pan = c.data[1:0];
            default: begin
            end
        endcase
    endfunction

    // one audio frame over all voices
    function automatic synth_pkg::stereo_t model_frame();
        int t, w, v, l, r, lv;
        synth_pkg::stereo_t s;
        l = 0;
        r = 0;
        for (int i = 0; i < synth_pkg::VOICES; i++) begin
            m_phase[i] = (m_phase[i] + int'(m_par[i].inc)) % 65536;
            lv = m_level[i];
            if (m_par[i].gate) begin
                lv = (lv + int'(m_par[i].atk) > 255) ? 255 : lv + int'(m_par[i].atk);
            end else begin
                lv = (lv > int'(m_par[i].rel)) ? lv - int'(m_par[i].rel) : 0;
            end
            m_level[i] = lv;
            t = m_phase[i] / 8;                 // top 13 bits
            w = (t < 4096) ? t - 2048 : 6143 - t;
            v = (w * lv * int'(m_par[i].vel)) >>> 12;
            if (m_par[i].pan != synth_pkg::PAN_RIGHT) begin
                l += v;
            end
            if (m_par[i].pan != synth_pkg::PAN_LEFT) begin
                r += v;
            end
        end
        s.left  = clip16(l);
        s.right = clip16(r);
        return s;
    endfunction

    task automatic compare_upto(string name, int upto);
        while (exp_q.size() < upto) begin
            exp_q.push_back(model_frame());
        end
        for (int i = n_cmp; i < upto; i++) begin
            check_stereo(name, exp_q[i], got_q[i]);
        end
        n_cmp = upto;
    endtask

    // sample waiting on the output, not yet in got_q
    task automatic check_held(string name);
        while (exp_q.size() <= got_q.size()) begin
            exp_q.push_back(model_frame());
        end
        check_stereo(name, exp_q[got_q.size()], sample);
    endtask

    // sequencer frozen once a sample sits unaccepted
    task automatic wait_stall();
        int n;
        n = 0;
        do begin
            @(negedge audio_clk);
            n++;
            if (n > TMO) begin
                abort_run("timed out waiting for a held sample with sample_ready low");
            end
        end while (!(sample_valid && !sample_ready));
    endtask

    task automatic wait_samples(int target);
        int n;
        n = 0;
        while (got_q.size() < target) begin
            @(negedge audio_clk);
            n++;
            if (n > TMO) begin
                abort_run("timed out waiting for output samples");
            end
        end
    endtask

    task automatic send_cmd(synth_pkg::reg_cmd_t c);
        int n;
        n = 0;
        cmd_valid = 1'b1;
        cmd       = c;
        do begin
            @(negedge audio_clk);
            n++;
            if (n > TMO) begin
                abort_run("timed out waiting for cmd_ready");
            end
        end while (!cmd_ready);
        @(posedge audio_clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic send_writes(step_t st);
        int n;
        n = 0;
        @(posedge audio_clk);
        #1;
        for (int i = 0; i < int'(st.count); i++) begin
            send_cmd(WR_TAB[int'(st.first) + i]);
            model_write(WR_TAB[int'(st.first) + i]);
        end
        do begin
            @(negedge audio_clk);
            n++;
            if (n > TMO) begin
                abort_run("last command was never applied");
            end
        end while (!cmd_ready);
    endtask

    task automatic run_step(int s);
        step_t st;
        int    target;
        st = STEPS[s];
        ready_mode = RDY_LOW;
        wait_stall();
        compare_upto(names[s], got_q.size());
        check_held(names[s]);                   // held sample uses the old params
        if (!st.live) begin
            send_writes(st);
        end
        ready_mode = st.mode;
        target     = got_q.size() + int'(st.frames);
        if (st.live) begin
            send_writes(st);
        end
        wait_samples(target);
        check_param(names[s], m_par[st.voice], dut.u_decode.params[st.voice]);
        compare_upto(names[s], target);
    endtask

    initial begin
        audio_clk    = 1'b0;
        arst_n       = 1'b0;
        cmd_valid    = 1'b0;
        cmd          = '0;
        sample_ready = 1'b0;
        ready_mode   = RDY_LOW;
        lfsr         = 16'd25;
        n_cmp        = 0;
        for (int i = 0; i < synth_pkg::VOICES; i++) begin
            m_par[i]   = '0;
            m_phase[i] = 0;
            m_level[i] = 0;
        end
        repeat (2) @(posedge audio_clk);
        #1;
        arst_n = 1'b1;
        for (int s = 0; s < 7; s++) begin
            run_step(s);
        end
        ready_mode = RDY_LOW;
        wait_stall();
        compare_upto("final", got_q.size());
        check_held("final");
        $display("Everything OK");
        $finish;
    end

endmodule

/* hw/synth_engine.sv */
module synth_engine (
    input  logic                 audio_clk,
    input  logic                 arst_n,
    input  logic                 cmd_valid,
    output logic                 cmd_ready,
    input  synth_pkg::reg_cmd_t  cmd,
    output logic                 sample_valid,
    input  logic                 sample_ready,
    output synth_pkg::stereo_t   sample
);

    synth_pkg::voice_param_t params [synth_pkg::VOICES];
    synth_pkg::slot_tok_t    tok;
    synth_pkg::voice_out_t   res;
    logic                    tok_valid;
    logic                    res_valid;
    logic                    frame_idle;
    logic                    frame_done;
    logic                    sample_pending;

    synth_reg_decode u_decode (
        .audio_clk      ( audio_clk ),
        .arst_n         ( arst_n ),
        .cmd_valid      ( cmd_valid ),
        .cmd_ready      ( cmd_ready ),
        .cmd            ( cmd ),
        .frame_idle     ( frame_idle ),     // writes land between frames
        .params         ( params )
    );

    synth_slot_seq u_seq (
        .audio_clk      ( audio_clk ),
        .arst_n         ( arst_n ),
        .frame_done     ( frame_done ),
        .sample_pending ( sample_pending ),  // back-pressure stall
        .tok_valid      ( tok_valid ),
        .tok            ( tok ),
        .frame_idle     ( frame_idle )
    );

    synth_voice_exec u_exec (
        .audio_clk      ( audio_clk ),
        .arst_n         ( arst_n ),
        .tok_valid      ( tok_valid ),
        .tok            ( tok ),
        .params         ( params ),
        .res_valid      ( res_valid ),
        .res            ( res )
    );

    synth_mixer u_mixer (
        .audio_clk      ( audio_clk ),
        .arst_n         ( arst_n ),
        .res_valid      ( res_valid ),
        .res            ( res ),
        .frame_done     ( frame_done ),
        .sample_pending ( sample_pending ),
        .sample_valid   ( sample_valid ),
        .sample_ready   ( sample_ready ),
        .sample         ( sample )
    );

endmodule

/* hw/synth_mixer.sv */
module synth_mixer (
    input  logic                   audio_clk,
    input  logic                   arst_n,
    input  logic                   res_valid,
    input  synth_pkg::voice_out_t  res,
    output logic                   frame_done,
    output logic                   sample_pending,
    output logic                   sample_valid,
    input  logic                   sample_ready,
    output synth_pkg::stereo_t     sample
);

    logic signed [synth_pkg::AUD_W+1:0] acc_l;
    logic signed [synth_pkg::AUD_W+1:0] acc_r;
    logic signed [synth_pkg::AUD_W+1:0] sum_l;
    logic signed [synth_pkg::AUD_W+1:0] sum_r;
    logic                               to_l;
    logic                               to_r;

    function automatic logic signed [synth_pkg::AUD_W-1:0] sat(
        input logic signed [synth_pkg::AUD_W+1:0] v
    );
        if (v > 18'sd32767) begin
            return 16'sh7fff;
        end else if (v < -18'sd32768) begin
            return 16'sh8000;
        end
        return v[synth_pkg::AUD_W-1:0];
    endfunction

    always_comb begin
        case (res.pan)
            synth_pkg::PAN_LEFT: begin
                to_l = 1'b1;
                to_r = 1'b0;
            end
            synth_pkg::PAN_RIGHT: begin
                to_l = 1'b0;
                to_r = 1'b1;
            end
            synth_pkg::PAN_CENTER: begin
                to_l = 1'b1;
                to_r = 1'b1;
            end
            default: begin
                to_l = 1'b1;                    // code 3 as center
                to_r = 1'b1;
            end
        endcase
        sum_l = acc_l + (to_l ? $signed(res.smp) : 16'sd0);
        sum_r = acc_r + (to_r ? $signed(res.smp) : 16'sd0);
    end

    assign sample_pending = sample_valid;

    always_ff @(posedge audio_clk or negedge arst_n) begin
        if (!arst_n) begin
            acc_l        <= '0;
            acc_r        <= '0;
            frame_done   <= 1'b1;
            sample_valid <= 1'b0;
        end else begin
            if (sample_valid && sample_ready) begin
                sample_valid <= 1'b0;
            end
            if (res_valid && res.last) begin
                acc_l        <= '0;
                acc_r        <= '0;
                frame_done   <= 1'b1;
                sample_valid <= 1'b1;
            end else if (res_valid) begin
                acc_l      <= sum_l;
                acc_r      <= sum_r;
                frame_done <= 1'b0;             // frame in progress
            end
        end
    end

    always_ff @(posedge audio_clk) begin
        if (res_valid && res.last) begin
            sample.left  <= sat(sum_l);
            sample.right <= sat(sum_r);
        end
    end

endmodule

/* hw/synth_pkg.sv */
package synth_pkg;

    localparam int VOICES  = 4;
    localparam int V_WIDTH = 2;                 // slot index
    localparam int PHASE_W = 16;
    localparam int AUD_W   = 16;
    localparam int WAVE_W  = 12;                // signed triangle

    // register offsets within one voice, low nibble of the address
    localparam logic [3:0] REG_INC_LO  = 4'd0;
    localparam logic [3:0] REG_INC_HI  = 4'd1;
    localparam logic [3:0] REG_GATE    = 4'd2;
    localparam logic [3:0] REG_VEL     = 4'd3;
    localparam logic [3:0] REG_ATTACK  = 4'd4;
    localparam logic [3:0] REG_RELEASE = 4'd5;
    localparam logic [3:0] REG_PAN     = 4'd6;

    localparam logic [1:0] PAN_CENTER = 2'd0;   // code 3 acts as center too
    localparam logic [1:0] PAN_LEFT   = 2'd1;
    localparam logic [1:0] PAN_RIGHT  = 2'd2;

    typedef struct packed {
        logic [7:0] addr;                       // voice in [7:4], register in [3:0]
        logic [7:0] data;
    } reg_cmd_t;

    typedef struct packed {
        logic [PHASE_W-1:0] inc;
        logic               gate;
        logic [7:0]         vel;
        logic [7:0]         atk;
        logic [7:0]         rel;
        logic [1:0]         pan;
    } voice_param_t;

    typedef struct packed {
        logic [V_WIDTH-1:0] slot;
        logic               last;
    } slot_tok_t;

    typedef struct packed {
        logic signed [AUD_W-1:0] smp;
        logic [1:0]              pan;
        logic                    last;
    } voice_out_t;

    typedef struct packed {
        logic signed [AUD_W-1:0] left;
        logic signed [AUD_W-1:0] right;
    } stereo_t;

endpackage

/* hw/synth_reg_decode.sv */
module synth_reg_decode (
    input  logic                    audio_clk,
    input  logic                    arst_n,
    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    input  synth_pkg::reg_cmd_t     cmd,
    input  logic                    frame_idle,
    output synth_pkg::voice_param_t params [synth_pkg::VOICES]
);

    synth_pkg::reg_cmd_t pend;
    logic                pend_valid;
    logic [3:0]          pend_voice;
    logic [3:0]          pend_reg;
    logic                apply;

    assign cmd_ready  = !pend_valid;            // single-entry buffer
    assign pend_voice = pend.addr[7:4];
    assign pend_reg   = pend.addr[3:0];
    assign apply      = pend_valid && frame_idle;

    always_ff @(posedge audio_clk) begin
        if (cmd_valid && cmd_ready) begin
            pend <= cmd;
        end
    end

    always_ff @(posedge audio_clk or negedge arst_n) begin
        if (!arst_n) begin
            pend_valid <= 1'b0;
        end else if (cmd_valid && cmd_ready) begin
            pend_valid <= 1'b1;
        end else if (apply) begin
            pend_valid <= 1'b0;                 // ready again next cycle
        end
    end

    // parameter registers, only touched between frames
    always_ff @(posedge audio_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < synth_pkg::VOICES; i++) begin
                params[i] <= '0;
            end
        end else if (apply && (int'(pend_voice) < synth_pkg::VOICES)) begin
            case (pend_reg)
                synth_pkg::REG_INC_LO: begin
                    params[pend_voice[synth_pkg::V_WIDTH-1:0]].inc[7:0] <= pend.data;
                end
                synth_pkg::REG_INC_HI: begin
                    params[pend_voice[synth_pkg::V_WIDTH-1:0]].inc[15:8] <= pend.data;
                end
                synth_pkg::REG_GATE: begin
                    params[pend_voice[synth_pkg::V_WIDTH-1:0]].gate <= pend.data[0];
                end
                synth_pkg::REG_VEL: begin
                    params[pend_voice[synth_pkg::V_WIDTH-1:0]].vel <= pend.data;
                end
                synth_pkg::REG_ATTACK: begin
                    params[pend_voice[synth_pkg::V_WIDTH-1:0]].atk <= pend.data;
                end
                synth_pkg::REG_RELEASE: begin
                    params[pend_voice[synth_pkg::V_WIDTH-1:0]].rel <= pend.data;
                end
                synth_pkg::REG_PAN: begin
                    params[pend_voice[synth_pkg::V_WIDTH-1:0]].pan <= pend.data[1:0];
                end
                default: begin
                end                             // unmapped offset, dropped
            endcase
        end
    end

endmodule

/* hw/synth_slot_seq.sv */
module synth_slot_seq (
    input  logic                  audio_clk,
    input  logic                  arst_n,
    input  logic                  frame_done,
    input  logic                  sample_pending,
    output logic                  tok_valid,
    output synth_pkg::slot_tok_t  tok,
    output logic                  frame_idle
);

    typedef enum logic {S_IDLE, S_ISSUE} state_t;

    state_t                        state;
    logic [synth_pkg::V_WIDTH-1:0] slot;
    logic                          start;

    assign start      = (state == S_IDLE) && frame_done && !sample_pending;
    assign frame_idle = (state == S_IDLE);
    assign tok_valid  = (state == S_ISSUE);
    assign tok.slot   = slot;
    assign tok.last   = (int'(slot) == synth_pkg::VOICES - 1);

    always_ff @(posedge audio_clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
            slot  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_ISSUE;
                    end
                end
                default: begin
                    slot <= slot + 1'b1;        // wraps to 0 after the last slot
                    if (tok.last) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

/* hw/synth_voice_exec.sv */
module synth_voice_exec (
    input  logic                    audio_clk,
    input  logic                    arst_n,
    input  logic                    tok_valid,
    input  synth_pkg::slot_tok_t    tok,
    input  synth_pkg::voice_param_t params [synth_pkg::VOICES],
    output logic                    res_valid,
    output synth_pkg::voice_out_t   res
);

    // per-voice state
    logic [synth_pkg::PHASE_W-1:0] phase_q [synth_pkg::VOICES];
    logic [7:0]                    level_q [synth_pkg::VOICES];

    synth_pkg::voice_param_t       p;
    logic [synth_pkg::PHASE_W-1:0] ph_new;
    logic [7:0]                    lvl_cur;
    logic [7:0]                    lvl_new;
    logic [8:0]                    atk_sum;

    // stage 1 registers
    logic                          s1_valid;
    logic [synth_pkg::PHASE_W-1:0] s1_phase;
    logic [7:0]                    s1_level;
    logic [7:0]                    s1_vel;
    logic [1:0]                    s1_pan;
    logic                          s1_last;

    // stage 2 datapath
    logic [12:0]                      t;
    logic signed [13:0]               tri_w;
    logic signed [synth_pkg::WAVE_W-1:0] wave;
    logic [15:0]                      gain;
    logic signed [28:0]               prod;

    always_comb begin
        p       = params[tok.slot];
        lvl_cur = level_q[tok.slot];
        ph_new  = phase_q[tok.slot] + p.inc;    // wraps mod 2^16
        atk_sum = {1'b0, lvl_cur} + {1'b0, p.atk};
        if (p.gate) begin
            lvl_new = atk_sum[8] ? 8'hff : atk_sum[7:0];
        end else begin
            lvl_new = (lvl_cur > p.rel) ? lvl_cur - p.rel : 8'h00;
        end
    end

    always_ff @(posedge audio_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < synth_pkg::VOICES; i++) begin
                phase_q[i] <= '0;
                level_q[i] <= '0;
            end
        end else if (tok_valid) begin
            phase_q[tok.slot] <= ph_new;        // write back
            level_q[tok.slot] <= lvl_new;
        end
    end

    always_ff @(posedge audio_clk) begin
        s1_phase <= ph_new;
        s1_level <= lvl_new;
        s1_vel   <= p.vel;                      // captured so a later write cannot leak in
        s1_pan   <= p.pan;
        s1_last  <= tok.last;
    end

    always_comb begin
        t     = s1_phase[synth_pkg::PHASE_W-1 -: 13];
        tri_w = t[12] ? 14'sd6143 - $signed({1'b0, t}) : $signed({1'b0, t}) - 14'sd2048;
        wave  = tri_w[synth_pkg::WAVE_W-1:0];
        gain  = s1_level * s1_vel;
        prod  = wave * $signed({1'b0, gain});
    end

    always_ff @(posedge audio_clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            s1_valid  <= tok_valid;
            res_valid <= s1_valid;
        end
    end

    always_ff @(posedge audio_clk) begin
        res.smp  <= prod[12 +: synth_pkg::AUD_W];  // >>> 12
        res.pan  <= s1_pan;
        res.last <= s1_last;
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the synth_engine testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module synth_engine_tb -o synth_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/synth_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation passed"
exit 0

/* src.f */
hw/synth_pkg.sv
hw/synth_reg_decode.sv
hw/synth_slot_seq.sv
hw/synth_voice_exec.sv
hw/synth_mixer.sv
hw/synth_engine.sv
dv/synth_engine_asserts.sv
dv/synth_engine_tb.sv
